// ==== common/pwm_cfg.svh ====
// PWM subsystem configuration
// Bus widths, channel block map and register field widths
`ifndef PWM_CFG_SVH
`define PWM_CFG_SVH

// --------------------------------------------------
// Wishbone bus
// --------------------------------------------------
`define BUS_ADR_W	32	// Byte address
`define BUS_DAT_W	32	// Full word per access

// --------------------------------------------------
// Block map
// --------------------------------------------------
`define BLK_SEL_HI	15	// Block number field
`define BLK_SEL_LO	8
`define CH0_BLOCK	8'h02	// Channel 0 block
`define CH1_BLOCK	8'h03	// Channel 1 block

// --------------------------------------------------
// Register fields
// --------------------------------------------------
`define DUTY_W		16	// Compare value
`define PRESC_W		16	// Tick divider
`define PERIOD_W	16	// Counter top

`endif

// ==== common/busPkg.sv ====
// Wishbone bus types
// Address and data words plus the offsets of the channel registers
`include "pwm_cfg.svh"

package busPkg;

	// --------------------------------------------------
	// Bus words
	// --------------------------------------------------
	typedef logic [`BUS_ADR_W-1:0] wbAdr;	// Byte address
	typedef logic [`BUS_DAT_W-1:0] wbDat;	// Read and write data

	// --------------------------------------------------
	// Channel register map
	// --------------------------------------------------
	// Low address byte inside a channel block
	typedef enum logic [7:0]
	{
		regCtrl		= 8'h00,	// Bit 0 enable
		regDuty		= 8'h04,	// Compare value
		regPresc	= 8'h08,	// Tick divider
		regPeriod	= 8'h0C		// Counter top
	} regOfs;

	// Anything else in the block reads as zero
	// and ignores writes

endpackage

// ==== common/pwmPkg.sv ====
// PWM channel types
// Field types of the channel settings and their reset values
`include "pwm_cfg.svh"

package pwmPkg;

	// --------------------------------------------------
	// Setting fields
	// --------------------------------------------------
	typedef logic [`DUTY_W-1:0]   dutyT;	// High time in ticks
	typedef logic [`PRESC_W-1:0]  prescT;	// Clocks per tick minus one
	typedef logic [`PERIOD_W-1:0] periodT;	// Last count of a period

	// --------------------------------------------------
	// Reset values
	// --------------------------------------------------
	// Channel comes up stopped
	localparam logic enableRst = 1'b0;

	// Slowest, longest settings until software writes
	localparam dutyT   dutyRst   = '1;
	localparam prescT  prescRst  = '1;
	localparam periodT periodRst = '1;

	// With these values the output is low only
	// in the last count of each period

endpackage

// ==== pwmChannel/pwmCsr.sv ====
// PWM channel register block
// Stores enable, duty, prescale and period and answers Wishbone cycles
`timescale 1ns/1ns

module pwmCsr
	import busPkg::*;
	import pwmPkg::*;
(
	input  logic	iSysClk,
	input  logic	reset,

	// Slave side, block already matched by decoder
	input  logic	stb,		// Request for this channel
	input  logic	we,
	input  wbAdr	adr,		// Only low byte decoded here
	input  wbDat	datWr,
	output logic	ack,
	output wbDat	datRd,

	// Settings to core
	output logic	enable,
	output dutyT	duty,
	output prescT	presc,
	output periodT	period
);

	// --------------------------------------------------
	// Request qualify
	// --------------------------------------------------
	logic		access;		// New request, not yet answered
	logic		wrAccess;	// Write part of it
	logic [7:0]	ofs;		// Register offset
	wbDat		rdSel;		// Read value of selected offset

	assign ofs = adr[7:0];

	// Master keeps stb up through the ack cycle
	assign access = stb & ~ack;
	assign wrAccess = access & we;

	// --------------------------------------------------
	// Setting registers
	// --------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			enable	<= enableRst;	// Stopped
			duty	<= dutyRst;
			presc	<= prescRst;
			period	<= periodRst;
		end
		else if (wrAccess)
		begin
			// Full word write, upper bits dropped
			case (ofs)
				regCtrl:	enable	<= datWr[0];
				regDuty:	duty	<= dutyT'(datWr);
				regPresc:	presc	<= prescT'(datWr);
				regPeriod:	period	<= periodT'(datWr);
				default:	;		// Unmapped offset, no effect
			endcase
		end
	end

	// --------------------------------------------------
	// Read select
	// --------------------------------------------------
	always_comb
	begin
		case (ofs)
			regCtrl:	rdSel = wbDat'(enable);	// Zero extended
			regDuty:	rdSel = wbDat'(duty);
			regPresc:	rdSel = wbDat'(presc);
			regPeriod:	rdSel = wbDat'(period);
			default:	rdSel = '0;		// Unknown offset reads zero
		endcase
	end

	// --------------------------------------------------
	// Response
	// --------------------------------------------------
	// One cycle ack, dropped while the master still holds stb
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= access;
	end

	// Read data captured with the ack
	// Valid only in the ack cycle
	always_ff @(posedge iSysClk)
	begin
		if (access)
			datRd <= rdSel;	// Old value on a write cycle
	end

endmodule

// ==== pwmChannel/pwmCore.sv ====
// PWM core for one channel
// Prescaler tick, period counter and registered duty compare
`timescale 1ns/1ns

module pwmCore
	import pwmPkg::*;
(
	input  logic	iSysClk,
	input  logic	reset,

	// Settings from register block
	input  logic	enable,
	input  dutyT	duty,
	input  prescT	presc,
	input  periodT	period,

	output logic	pwmOut
);

	// --------------------------------------------------
	// Prescaler
	// --------------------------------------------------
	prescT	preCnt;		// Clocks into current tick
	logic	tick;		// One cycle every presc+1 clocks

	// Greater-or-equal so a lowered presc wraps at once
	assign tick = enable && (preCnt >= presc);

	always_ff @(posedge iSysClk)
	begin
		if (reset || !enable)
			preCnt <= '0;				// Held while stopped
		else if (tick)
			preCnt <= '0;
		else
			preCnt <= preCnt + prescT'(1);
	end

	// --------------------------------------------------
	// Period counter
	// --------------------------------------------------
	periodT	perCnt;		// Position inside PWM period

	always_ff @(posedge iSysClk)
	begin
		if (reset || !enable)
			perCnt <= '0;				// Restart from zero on enable
		else if (tick)
		begin
			// Wrap at top, also when period shrinks below count
			if (perCnt >= period)
				perCnt <= '0;
			else
				perCnt <= perCnt + periodT'(1);
		end
	end

	// --------------------------------------------------
	// Compare output
	// --------------------------------------------------
	// High below duty, so duty above period keeps it high
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			pwmOut <= 1'b0;
		else
			pwmOut <= enable && (perCnt < duty);	// Low when stopped
	end

endmodule

// ==== src/wbDecoder.sv ====
// Wishbone address decoder
// Steers one master to two channel slaves and acks unmapped cycles
`timescale 1ns/1ns

module wbDecoder
	import busPkg::*;
(
	input  logic	iSysClk,
	input  logic	reset,

	// Master side
	input  logic	cyc,
	input  logic	stb,
	input  wbAdr	adr,
	output logic	ack,
	output wbDat	datRd,

	// Channel slaves
	output logic	chStb0,
	output logic	chStb1,
	input  logic	chAck0,
	input  logic	chAck1,
	input  wbDat	chDat0,
	input  wbDat	chDat1
);

	`include "pwm_cfg.svh"

	// --------------------------------------------------
	// Block match
	// --------------------------------------------------
	logic	req;		// Valid bus request
	logic	hit0;
	logic	hit1;
	logic	missAck;	// Own ack for unmapped blocks

	assign req  = cyc & stb;
	assign hit0 = (adr[`BLK_SEL_HI:`BLK_SEL_LO] == `CH0_BLOCK);
	assign hit1 = (adr[`BLK_SEL_HI:`BLK_SEL_LO] == `CH1_BLOCK);

	assign chStb0 = req & hit0;	// At most one strobe
	assign chStb1 = req & hit1;

	// --------------------------------------------------
	// Unmapped response
	// --------------------------------------------------
	// Same one cycle ack as a channel so the bus never hangs
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			missAck <= 1'b0;
		else
			missAck <= req & ~hit0 & ~hit1 & ~missAck;
	end

	// --------------------------------------------------
	// Return mux
	// --------------------------------------------------
	assign ack = chAck0 | chAck1 | missAck;

	always_comb
	begin
		if (chAck0)
			datRd = chDat0;
		else if (chAck1)
			datRd = chDat1;
		else
			datRd = '0;		// Unmapped or idle
	end

endmodule

// ==== src/pwmSubsystem.sv ====
// Two channel PWM subsystem
// Wishbone slave port, address decoder, two register blocks and two cores
`timescale 1ns/1ns

module pwmSubsystem
	import busPkg::*;
	import pwmPkg::*;
(
	input  logic		iSysClk,
	input  logic		reset,

	// Wishbone classic slave
	input  logic		cyc,
	input  logic		stb,
	input  logic		we,
	input  wbAdr		adr,
	input  wbDat		datWr,
	output logic		ack,
	output wbDat		datRd,

	output logic [1:0]	pwmOut	// One bit per channel
);

	// --------------------------------------------------
	// Internal nets
	// --------------------------------------------------
	logic	chStb0, chStb1;		// Decoder strobes
	logic	chAck0, chAck1;		// Channel acks
	wbDat	chDat0, chDat1;		// Channel read data

	logic	enable0, enable1;	// Settings per channel
	dutyT	duty0, duty1;
	prescT	presc0, presc1;
	periodT	period0, period1;

	// --------------------------------------------------
	// Bus decode
	// --------------------------------------------------
	wbDecoder decoder_i
	(
		.iSysClk(iSysClk),	.reset(reset),
		.cyc(cyc),		.stb(stb),
		.adr(adr),		.ack(ack),
		.datRd(datRd),
		.chStb0(chStb0),	.chStb1(chStb1),
		.chAck0(chAck0),	.chAck1(chAck1),
		.chDat0(chDat0),	.chDat1(chDat1)
	);

	// --------------------------------------------------
	// Channel 0
	// --------------------------------------------------
	pwmCsr csr0_i
	(
		.iSysClk(iSysClk),	.reset(reset),
		.stb(chStb0),		.we(we),
		.adr(adr),		.datWr(datWr),
		.ack(chAck0),		.datRd(chDat0),
		.enable(enable0),	.duty(duty0),
		.presc(presc0),		.period(period0)
	);

	pwmCore core0_i
	(
		.iSysClk(iSysClk),	.reset(reset),
		.enable(enable0),	.duty(duty0),
		.presc(presc0),		.period(period0),
		.pwmOut(pwmOut[0])
	);

	// --------------------------------------------------
	// Channel 1
	// --------------------------------------------------
	pwmCsr csr1_i
	(
		.iSysClk(iSysClk),	.reset(reset),
		.stb(chStb1),		.we(we),
		.adr(adr),		.datWr(datWr),
		.ack(chAck1),		.datRd(chDat1),
		.enable(enable1),	.duty(duty1),
		.presc(presc1),		.period(period1)
	);

	pwmCore core1_i
	(
		.iSysClk(iSysClk),	.reset(reset),
		.enable(enable1),	.duty(duty1),
		.presc(presc1),		.period(period1),
		.pwmOut(pwmOut[1])
	);

endmodule

// ==== test/pwmSubsystem_properties.sv ====
// PWM subsystem bound checks
// Wishbone handshake, stopped outputs and duty ratio of channel 0
`timescale 1ns/1ns
`include "pwm_cfg.svh"

module pwmSubsystem_properties
	import busPkg::*;
	import pwmPkg::*;
(
	input  logic		iSysClk,
	input  logic		reset,
	input  logic		cyc,
	input  logic		stb,
	input  logic		ack,
	input  wbAdr		adr,
	input  wbDat		datRd,
	input  logic [1:0]	pwmOut,
	input  logic		enable0,
	input  logic		enable1,
	input  dutyT		duty0,
	input  prescT		presc0,
	input  periodT		period0
);

	bit		assertFail = 1'b0;	// Sticky, polled by testbench

	logic		newReq;			// Request not yet acked
	logic		unmapped;		// Block matches no channel

	assign newReq = cyc && stb && !ack;
	assign unmapped = (adr[`BLK_SEL_HI:`BLK_SEL_LO] != `CH0_BLOCK) &&
		(adr[`BLK_SEL_HI:`BLK_SEL_LO] != `CH1_BLOCK);

	// --------------------------------------------------
	// Duty window on channel 0
	// --------------------------------------------------
	logic		outPrev;		// Output one cycle back
	dutyT		dutyQ;
	prescT		prescQ;
	periodT		periodQ;
	logic		settingsMoved;		// Window no longer valid
	logic [33:0]	winLen;			// Clocks per PWM period
	logic [33:0]	expHigh;		// High clocks per period
	logic [33:0]	winLeft;
	logic [33:0]	highCnt;
	logic		winDone;		// Count complete, one cycle

	assign settingsMoved = !enable0 || (duty0 != dutyQ) ||
		(presc0 != prescQ) || (period0 != periodQ);
	assign winLen = (34'(period0) + 34'd1) * (34'(presc0) + 34'd1);
	// Duty above the top means high all period
	assign expHigh = ((duty0 > period0) ? (34'(period0) + 34'd1) : 34'(duty0)) *
		(34'(presc0) + 34'd1);

	always_ff @(posedge iSysClk)
	begin
		outPrev <= pwmOut[0];
		dutyQ <= duty0;
		prescQ <= presc0;
		periodQ <= period0;
		winDone <= 1'b0;
		if (reset || settingsMoved)
		begin
			winLeft <= '0;			// Drop partial window
			highCnt <= '0;
		end
		else if (winLeft == '0)
		begin
			if (pwmOut[0] && !outPrev)	// Period starts at rising output
			begin
				winLeft <= winLen - 34'd1;
				highCnt <= 34'd1;
			end
		end
		else
		begin
			winLeft <= winLeft - 34'd1;
			highCnt <= highCnt + 34'(pwmOut[0]);
			winDone <= (winLeft == 34'd1);
		end
	end

	// --------------------------------------------------
	// Handshake
	// --------------------------------------------------
	apAckFollows: assert property (@(posedge iSysClk) disable iff (reset)
		newReq |=> ack)
	else
	begin
		assertFail = 1'b1;
		$error("ack missing one cycle after a request");
	end

	apAckSingle: assert property (@(posedge iSysClk) disable iff (reset)
		ack |=> !ack)
	else
	begin
		assertFail = 1'b1;
		$error("ack held longer than one cycle");
	end

	apAckHasReq: assert property (@(posedge iSysClk) disable iff (reset)
		ack |-> $past(newReq))
	else
	begin
		assertFail = 1'b1;
		$error("ack without a request");
	end

	apMissZero: assert property (@(posedge iSysClk) disable iff (reset)
		(newReq && unmapped) |=> (datRd == '0))
	else
	begin
		assertFail = 1'b1;
		$error("unmapped block returned nonzero data");
	end

	// --------------------------------------------------
	// PWM outputs
	// --------------------------------------------------
	apOffLow0: assert property (@(posedge iSysClk) disable iff (reset)
		!enable0 |=> !pwmOut[0])
	else
	begin
		assertFail = 1'b1;
		$error("channel 0 output high while disabled");
	end

	apOffLow1: assert property (@(posedge iSysClk) disable iff (reset)
		!enable1 |=> !pwmOut[1])
	else
	begin
		assertFail = 1'b1;
		$error("channel 1 output high while disabled");
	end

	apDutyWindow: assert property (@(posedge iSysClk) disable iff (reset)
		winDone |-> (highCnt == expHigh))
	else
	begin
		assertFail = 1'b1;
		$error("channel 0 high time per period is wrong");
	end

endmodule

bind pwmSubsystem pwmSubsystem_properties props_i
(
	.iSysClk(iSysClk),	.reset(reset),
	.cyc(cyc),		.stb(stb),
	.ack(ack),		.adr(adr),
	.datRd(datRd),		.pwmOut(pwmOut),
	.enable0(enable0),	.enable1(enable1),
	.duty0(duty0),		.presc0(presc0),
	.period0(period0)
);

// ==== test/tb_pwmSubsystem.sv ====
// Testbench for the two channel PWM subsystem
// Wishbone bus tasks, LFSR register values, readback and output checks
`timescale 1ns/1ns
`include "pwm_cfg.svh"

module tb_pwmSubsystem
	import busPkg::*;
();

	localparam int TIMEOUT_CYCLES = 20000;	// Whole run needs well under 1000

	logic		iSysClk = 1'b0;
	logic		reset;
	logic		cyc;
	logic		stb;
	logic		we;
	wbAdr		adr;
	wbDat		datWr;
	logic		ack;
	wbDat		datRd;
	logic [1:0]	pwmOut;

	logic [15:0]	lfsrState = 16'd74;	// Seed
	int		cycleCnt = 0;

	pwmSubsystem dut_i
	(
		.iSysClk(iSysClk),	.reset(reset),
		.cyc(cyc),		.stb(stb),
		.we(we),		.adr(adr),
		.datWr(datWr),		.ack(ack),
		.datRd(datRd),		.pwmOut(pwmOut)
	);

	always #5 iSysClk = ~iSysClk;		// 10 ns period

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic abortRun();
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic drawBits(input int n, output wbDat v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);	// One step per bit
			v = {v[30:0], lfsrState[0]};
		end
	endtask

	function automatic wbAdr regAddr(input int ch, input logic [7:0] ofs);
		logic [7:0] blk;
		blk = (ch == 0) ? `CH0_BLOCK : `CH1_BLOCK;
		return {16'h0000, blk, ofs};
	endfunction

	// One classic cycle, inputs change 1 ns after the edge
	task automatic busAccess(input logic wrEn, input wbAdr a, input wbDat d,
		output wbDat q);
		@(posedge iSysClk);
		#1;
		cyc = 1'b1;
		stb = 1'b1;
		we = wrEn;
		adr = a;
		datWr = d;
		do
			@(negedge iSysClk);		// Sample mid cycle
		while (!ack);
		q = datRd;
		@(posedge iSysClk);
		#1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic writeReg(input wbAdr a, input wbDat d);
		wbDat unused;
		busAccess(1'b1, a, d, unused);
	endtask

	task automatic checkRead(input string name, input wbAdr a, input wbDat exp);
		wbDat got;
		busAccess(1'b0, a, '0, got);
		assert (got === exp)
		else
		begin
			$display("FAIL %s expected %h actual %h", name, exp, got);
			abortRun();
		end
	endtask

	task automatic checkOutputs(input string name, input logic [1:0] exp);
		assert (pwmOut === exp)
		else
		begin
			$display("FAIL %s expected %b actual %b", name, exp, pwmOut);
			abortRun();
		end
	endtask

	// Bound duty counter finishes one period
	task automatic waitWindow();
		do
			@(negedge iSysClk);
		while (!dut_i.props_i.winDone);
	endtask

	// --------------------------------------------------
	// Watchdog
	// --------------------------------------------------
	always @(posedge iSysClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the tests did not finish", cycleCnt);
			abortRun();
		end
		else if (dut_i.props_i.assertFail)
		begin
			$display("A bound assertion on the DUT failed");
			abortRun();
		end
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		wbDat val;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datWr = '0;
		repeat (16) @(posedge iSysClk);
		#1;
		reset = 1'b0;

		// Reset values of both channels
		for (int ch = 0; ch < 2; ch++)
		begin
			checkRead($sformatf("reset ctrl ch%0d", ch), regAddr(ch, regCtrl), 32'h0);
			checkRead($sformatf("reset duty ch%0d", ch), regAddr(ch, regDuty), 32'hFFFF);
			checkRead($sformatf("reset presc ch%0d", ch), regAddr(ch, regPresc), 32'hFFFF);
			checkRead($sformatf("reset period ch%0d", ch), regAddr(ch, regPeriod), 32'hFFFF);
		end
		checkOutputs("reset outputs", 2'b00);

		// Random full words, 16 bits kept
		for (int round = 0; round < 4; round++)
		begin
			for (int ch = 0; ch < 2; ch++)
			begin
				drawBits(32, val);
				writeReg(regAddr(ch, regDuty), val);
				checkRead($sformatf("duty ch%0d", ch), regAddr(ch, regDuty),
					val & 32'h0000_FFFF);
				drawBits(32, val);
				writeReg(regAddr(ch, regPresc), val);
				checkRead($sformatf("presc ch%0d", ch), regAddr(ch, regPresc),
					val & 32'h0000_FFFF);
				drawBits(32, val);
				writeReg(regAddr(ch, regPeriod), val);
				checkRead($sformatf("period ch%0d", ch), regAddr(ch, regPeriod),
					val & 32'h0000_FFFF);
			end
		end
		checkRead("unmapped offset", regAddr(0, 8'h10), 32'h0);

		// Block 0x07 belongs to no channel
		writeReg(32'h0000_0704, 32'hDEAD_BEEF);
		checkRead("unmapped block", 32'h0000_0704, 32'h0);

		// 3 of 10 counts, 2 clocks each
		writeReg(regAddr(0, regPresc), 32'd1);
		writeReg(regAddr(0, regPeriod), 32'd9);
		writeReg(regAddr(0, regDuty), 32'd3);
		writeReg(regAddr(0, regCtrl), 32'd1);
		checkRead("ctrl enabled ch0", regAddr(0, regCtrl), 32'd1);
		waitWindow();

		// Duty past the top, high all period
		writeReg(regAddr(0, regCtrl), 32'd0);
		writeReg(regAddr(0, regDuty), 32'd12);
		writeReg(regAddr(0, regCtrl), 32'd1);
		waitWindow();

		// Channel 1 stays stopped, its writes leave channel 0 alone
		checkOutputs("ch0 running ch1 idle", 2'b01);
		writeReg(regAddr(1, regDuty), 32'd5);
		writeReg(regAddr(1, regPeriod), 32'd7);
		checkRead("ch0 duty after ch1 write", regAddr(0, regDuty), 32'd12);
		checkRead("ch0 presc after ch1 write", regAddr(0, regPresc), 32'd1);
		checkRead("ch0 period after ch1 write", regAddr(0, regPeriod), 32'd9);
		checkRead("ch0 ctrl after ch1 write", regAddr(0, regCtrl), 32'd1);
		checkRead("ch1 duty", regAddr(1, regDuty), 32'd5);
		checkOutputs("ch1 still idle", 2'b01);

		if (dut_i.props_i.assertFail)
		begin
			$display("A bound assertion on the DUT failed before the end");
			abortRun();
		end
		else
		begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// ==== build.f ====
+incdir+common
common/busPkg.sv
common/pwmPkg.sv
pwmChannel/pwmCsr.sv
pwmChannel/pwmCore.sv
src/wbDecoder.sv
src/pwmSubsystem.sv
test/pwmSubsystem_properties.sv
test/tb_pwmSubsystem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PWM subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f build.f \
	--top-module tb_pwmSubsystem

# Exit status is nonzero when the testbench stops with $fatal
./obj_dir/Vtb_pwmSubsystem +verilator+error+limit+100
